/* build.f */
hw/noc_pkg.sv
hw/flit_fifo.sv
hw/rr_arbiter.sv
hw/noc_router.sv
hw/network_interface.sv
hw/start_delay_gen.sv
hw/noc_top.sv
sim/noc_sva.sv
sim/noc_tb.sv

/* hw/flit_fifo.sv */
`timescale 1ns/10ps

module flit_fifo #(
	parameter int  DEPTH = 4,
	parameter type payload_t = noc_pkg::flit_t
) (
	input  logic     clk,
	input  logic     reset,
	input  logic     wr_i,
	input  payload_t wr_data_i,
	input  logic     rd_i,
	output payload_t rd_data_o,
	output logic     empty_o,
	output logic     full_o
);

	payload_t mem [DEPTH];
	logic [$clog2(DEPTH)-1:0] wr_ptr;
	logic [$clog2(DEPTH)-1:0] rd_ptr;
	logic [$clog2(DEPTH):0] count;
	logic push;
	logic pop;

	assign push = wr_i && !full_o;
	assign pop = rd_i && !empty_o;	// head leaves in the same cycle
	assign empty_o = (count == '0);
	assign full_o = (int'(count) == DEPTH);
	assign rd_data_o = mem[rd_ptr];

	always_ff @(posedge clk) begin
		if (push) mem[wr_ptr] <= wr_data_i;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) wr_ptr <= (int'(wr_ptr) == DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop) rd_ptr <= (int'(rd_ptr) == DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: ;	// both or neither
			endcase
		end
	end

endmodule

/* hw/network_interface.sv */
`timescale 1ns/10ps

module network_interface #(
	parameter int NODE_ID = 0
) (
	input  logic           clk,
	input  logic           reset,
	input  logic           start_i,
	input  noc_pkg::link_t core_in_i,
	output logic           core_credit_o,
	output noc_pkg::link_t core_out_o,
	input  logic           core_credit_i,
	output noc_pkg::link_t rtr_out_o,
	input  logic           rtr_credit_i,
	input  noc_pkg::link_t rtr_in_i,
	output logic           rtr_credit_o
);

	noc_pkg::core_req_t inj_req;
	noc_pkg::core_req_t inj_head;
	logic inj_empty;
	logic inj_pop;
	noc_pkg::flit_t ej_head;
	logic ej_empty;
	logic ej_pop;
	logic [noc_pkg::CRD_W-1:0] rtr_crd;	// space in the router input fifo
	logic [noc_pkg::CRD_W-1:0] core_crd;	// space the core has granted
	logic rtr_vld;
	logic core_vld;
	noc_pkg::flit_t rtr_flit;
	noc_pkg::flit_t core_flit;
	logic inj_crd_q;
	logic ej_crd_q;

	assign inj_req = '{dst_x: core_in_i.flit.dst_x, dst_y: core_in_i.flit.dst_y,
	                   data: core_in_i.flit.data};

	flit_fifo #(.DEPTH(noc_pkg::INJ_DEPTH), .payload_t(noc_pkg::core_req_t)) i_inj_fifo (
		.clk(clk), .reset(reset), .wr_i(core_in_i.valid), .wr_data_i(inj_req),
		.rd_i(inj_pop), .rd_data_o(inj_head), .empty_o(inj_empty), .full_o()
	);

	flit_fifo #(.DEPTH(noc_pkg::EJ_DEPTH), .payload_t(noc_pkg::flit_t)) i_ej_fifo (
		.clk(clk), .reset(reset), .wr_i(rtr_in_i.valid), .wr_data_i(rtr_in_i.flit),
		.rd_i(ej_pop), .rd_data_o(ej_head), .empty_o(ej_empty), .full_o()
	);

	// held back until this node is released
	assign inj_pop = start_i && !inj_empty && (rtr_vld ? (rtr_crd > 1) : (rtr_crd != '0));
	assign ej_pop = !ej_empty && (core_vld ? (core_crd > 1) : (core_crd != '0));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rtr_vld <= 1'b0;
			core_vld <= 1'b0;
			rtr_crd <= noc_pkg::CRD_W'(noc_pkg::BUF_DEPTH);
			core_crd <= '0;	// core grants eject space itself
			inj_crd_q <= 1'b0;
			ej_crd_q <= 1'b0;
		end else begin
			rtr_vld <= inj_pop;
			core_vld <= ej_pop;
			inj_crd_q <= inj_pop;
			ej_crd_q <= ej_pop;
			case ({rtr_credit_i, rtr_vld})
				2'b10: rtr_crd <= rtr_crd + 1'b1;
				2'b01: rtr_crd <= rtr_crd - 1'b1;
				default: ;
			endcase
			case ({core_credit_i, core_vld})
				2'b10: core_crd <= core_crd + 1'b1;
				2'b01: core_crd <= core_crd - 1'b1;
				default: ;
			endcase
		end
	end

	always_ff @(posedge clk) begin
		if (inj_pop) rtr_flit <= '{dst_x: inj_head.dst_x, dst_y: inj_head.dst_y,
		                           src: noc_pkg::SW'(NODE_ID), data: inj_head.data};
		if (ej_pop) core_flit <= ej_head;
	end

	assign rtr_out_o = '{valid: rtr_vld, flit: rtr_flit};
	assign core_out_o = '{valid: core_vld, flit: core_flit};
	assign core_credit_o = inj_crd_q;
	assign rtr_credit_o = ej_crd_q;

endmodule

/* hw/noc_pkg.sv */
package noc_pkg;

	localparam int NX = 3;	// mesh columns
	localparam int NY = 3;	// mesh rows
	localparam int NC = NX * NY;	// cores
	localparam int XW = 2;
	localparam int YW = 2;
	localparam int SW = $clog2(NC);	// source field width
	localparam int P = 5;	// ports per router
	localparam int PW = $clog2(P);
	localparam int BUF_DEPTH = 4;	// router input fifo
	localparam int INJ_DEPTH = 4;	// injection queue, also initial core credit
	localparam int EJ_DEPTH = 2;	// ejection buffer
	localparam int CRD_W = $clog2(BUF_DEPTH + 1);
	localparam int DATA_W = 16;

	typedef enum logic [PW-1:0] {
		LOCAL = 0,
		EAST  = 1,
		NORTH = 2,
		WEST  = 3,
		SOUTH = 4
	} port_e;

	typedef struct packed {
		logic [XW-1:0]     dst_x;
		logic [YW-1:0]     dst_y;
		logic [SW-1:0]     src;	// source core number
		logic [DATA_W-1:0] data;
	} flit_t;

	typedef struct packed {
		logic  valid;
		flit_t flit;
	} link_t;

	// what a core hands to its interface, source is added on injection
	typedef struct packed {
		logic [XW-1:0]     dst_x;
		logic [YW-1:0]     dst_y;
		logic [DATA_W-1:0] data;
	} core_req_t;

endpackage

/* hw/noc_router.sv */
`timescale 1ns/10ps

module noc_router (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [noc_pkg::XW-1:0] x_i,
	input  logic [noc_pkg::YW-1:0] y_i,
	input  noc_pkg::link_t         in_i [noc_pkg::P],
	output logic                   credit_o [noc_pkg::P],
	output noc_pkg::link_t         out_o [noc_pkg::P],
	input  logic                   credit_i [noc_pkg::P]
);

	noc_pkg::flit_t head [noc_pkg::P];	// fifo heads
	logic [noc_pkg::P-1:0] empty;
	logic [noc_pkg::P-1:0] pop;
	logic [noc_pkg::P-1:0] credit_q;
	noc_pkg::port_e dest [noc_pkg::P];	// route of each head
	logic [noc_pkg::P-1:0] req [noc_pkg::P];	// indexed by output, then input
	logic [noc_pkg::P-1:0] gnt [noc_pkg::P];
	logic crd_free [noc_pkg::P];
	logic [noc_pkg::CRD_W-1:0] crd_cnt [noc_pkg::P];

	for (genvar i = 0; i < noc_pkg::P; i++) begin : g_in
		flit_fifo #(
			.DEPTH     (noc_pkg::BUF_DEPTH),
			.payload_t (noc_pkg::flit_t)
		) i_fifo (
			.clk       (clk),
			.reset     (reset),
			.wr_i      (in_i[i].valid),	// written on the arrival edge
			.wr_data_i (in_i[i].flit),
			.rd_i      (pop[i]),
			.rd_data_o (head[i]),
			.empty_o   (empty[i]),
			.full_o    ()
		);

		assign credit_o[i] = credit_q[i];
	end

	// XY routing, x first then y
	always_comb begin
		for (int i = 0; i < noc_pkg::P; i++) begin
			if (head[i].dst_x > x_i) dest[i] = noc_pkg::EAST;
			else if (head[i].dst_x < x_i) dest[i] = noc_pkg::WEST;
			else if (head[i].dst_y < y_i) dest[i] = noc_pkg::NORTH;	// north is y-1
			else if (head[i].dst_y > y_i) dest[i] = noc_pkg::SOUTH;
			else dest[i] = noc_pkg::LOCAL;
		end
	end

	// a head without credit downstream just waits in its fifo
	always_comb begin
		for (int o = 0; o < noc_pkg::P; o++) begin
			for (int i = 0; i < noc_pkg::P; i++) begin
				req[o][i] = !empty[i] && (dest[i] == noc_pkg::port_e'(o)) && crd_free[o];
			end
		end
	end

	always_comb begin
		pop = '0;
		for (int o = 0; o < noc_pkg::P; o++) begin
			pop = pop | gnt[o];	// each input asks for one output only
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) credit_q <= '0;
		else credit_q <= pop;	// slot freed, tell the sender
	end

	for (genvar o = 0; o < noc_pkg::P; o++) begin : g_out
		logic [noc_pkg::CRD_W-1:0] crd;
		logic vld;
		noc_pkg::flit_t sel;
		noc_pkg::flit_t flit_q;

		rr_arbiter i_arb (
			.clk   (clk),
			.reset (reset),
			.req_i (req[o]),
			.gnt_o (gnt[o])
		);

		always_comb begin
			sel = head[0];
			for (int i = 0; i < noc_pkg::P; i++) begin
				if (gnt[o][i]) sel = head[i];
			end
		end

		// the registered flit still owes its credit
		assign crd_free[o] = vld ? (crd > 1) : (crd != '0);

		always_ff @(posedge clk or posedge reset) begin
			if (reset) begin
				vld <= 1'b0;
				// local output drains into the smaller ejection buffer
				crd <= (o == noc_pkg::LOCAL) ? noc_pkg::CRD_W'(noc_pkg::EJ_DEPTH)
				                             : noc_pkg::CRD_W'(noc_pkg::BUF_DEPTH);
			end else begin
				vld <= |gnt[o];
				case ({credit_i[o], vld})
					2'b10: crd <= crd + 1'b1;
					2'b01: crd <= crd - 1'b1;
					default: ;
				endcase
			end
		end

		always_ff @(posedge clk) begin
			if (|gnt[o]) flit_q <= sel;
		end

		assign crd_cnt[o] = crd;
		assign out_o[o] = '{valid: vld, flit: flit_q};
	end

endmodule

/* hw/noc_top.sv */
`timescale 1ns/10ps

module noc_top (
	input  logic           clk,
	input  logic           reset,
	input  logic           start_i,
	input  noc_pkg::link_t inj_flit_i [noc_pkg::NC],
	output logic           inj_credit_o [noc_pkg::NC],
	output noc_pkg::link_t ej_flit_o [noc_pkg::NC],
	input  logic           ej_credit_i [noc_pkg::NC]
);

	noc_pkg::link_t rtr_in [noc_pkg::NC][noc_pkg::P];
	logic rtr_crd_o [noc_pkg::NC][noc_pkg::P];	// from router inputs back upstream
	noc_pkg::link_t rtr_out [noc_pkg::NC][noc_pkg::P];
	logic rtr_crd_i [noc_pkg::NC][noc_pkg::P];	// into router output counters
	logic [noc_pkg::NC-1:0] node_start;

	start_delay_gen i_start_delay_gen (
		.clk     (clk),
		.reset   (reset),
		.start_i (start_i),
		.start_o (node_start)
	);

	// node n sits at x = n % NX, y = n / NX
	for (genvar n = 0; n < noc_pkg::NC; n++) begin : g_node
		noc_router i_router (
			.clk      (clk),
			.reset    (reset),
			.x_i      (noc_pkg::XW'(n % noc_pkg::NX)),
			.y_i      (noc_pkg::YW'(n / noc_pkg::NX)),
			.in_i     (rtr_in[n]),
			.credit_o (rtr_crd_o[n]),
			.out_o    (rtr_out[n]),
			.credit_i (rtr_crd_i[n])
		);

		network_interface #(.NODE_ID(n)) i_ni (
			.clk           (clk),
			.reset         (reset),
			.start_i       (node_start[n]),
			.core_in_i     (inj_flit_i[n]),
			.core_credit_o (inj_credit_o[n]),
			.core_out_o    (ej_flit_o[n]),
			.core_credit_i (ej_credit_i[n]),
			.rtr_out_o     (rtr_in[n][noc_pkg::LOCAL]),
			.rtr_credit_i  (rtr_crd_o[n][noc_pkg::LOCAL]),
			.rtr_in_i      (rtr_out[n][noc_pkg::LOCAL]),
			.rtr_credit_o  (rtr_crd_i[n][noc_pkg::LOCAL])
		);

		if (n % noc_pkg::NX < noc_pkg::NX - 1) begin : g_east
			assign rtr_in[n][noc_pkg::EAST] = rtr_out[n + 1][noc_pkg::WEST];
			assign rtr_crd_i[n][noc_pkg::EAST] = rtr_crd_o[n + 1][noc_pkg::WEST];
		end else begin : g_east_edge
			assign rtr_in[n][noc_pkg::EAST] = '0;	// mesh edge, nothing attached
			assign rtr_crd_i[n][noc_pkg::EAST] = 1'b0;
		end

		if (n >= noc_pkg::NX) begin : g_north
			assign rtr_in[n][noc_pkg::NORTH] = rtr_out[n - noc_pkg::NX][noc_pkg::SOUTH];
			assign rtr_crd_i[n][noc_pkg::NORTH] = rtr_crd_o[n - noc_pkg::NX][noc_pkg::SOUTH];
		end else begin : g_north_edge
			assign rtr_in[n][noc_pkg::NORTH] = '0;
			assign rtr_crd_i[n][noc_pkg::NORTH] = 1'b0;
		end

		if (n % noc_pkg::NX > 0) begin : g_west
			assign rtr_in[n][noc_pkg::WEST] = rtr_out[n - 1][noc_pkg::EAST];
			assign rtr_crd_i[n][noc_pkg::WEST] = rtr_crd_o[n - 1][noc_pkg::EAST];
		end else begin : g_west_edge
			assign rtr_in[n][noc_pkg::WEST] = '0;
			assign rtr_crd_i[n][noc_pkg::WEST] = 1'b0;
		end

		if (n < noc_pkg::NC - noc_pkg::NX) begin : g_south
			assign rtr_in[n][noc_pkg::SOUTH] = rtr_out[n + noc_pkg::NX][noc_pkg::NORTH];
			assign rtr_crd_i[n][noc_pkg::SOUTH] = rtr_crd_o[n + noc_pkg::NX][noc_pkg::NORTH];
		end else begin : g_south_edge
			assign rtr_in[n][noc_pkg::SOUTH] = '0;
			assign rtr_crd_i[n][noc_pkg::SOUTH] = 1'b0;
		end
	end

endmodule

/* hw/rr_arbiter.sv */
`timescale 1ns/10ps

module rr_arbiter (
	input  logic                   clk,
	input  logic                   reset,
	input  logic [noc_pkg::P-1:0]  req_i,
	output logic [noc_pkg::P-1:0]  gnt_o
);

	logic [noc_pkg::PW-1:0] ptr;	// highest priority requester
	logic [noc_pkg::PW-1:0] win;
	logic found;

	// scan from the pointer, wrapping past the last requester
	always_comb begin
		gnt_o = '0;
		win = ptr;
		found = 1'b0;
		for (int i = 0; i < noc_pkg::P; i++) begin
			if (!found && req_i[(int'(ptr) + i) % noc_pkg::P]) begin
				found = 1'b1;
				win = noc_pkg::PW'((int'(ptr) + i) % noc_pkg::P);
			end
		end
		if (found) gnt_o[win] = 1'b1;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			ptr <= '0;
		end else if (found) begin
			ptr <= (int'(win) == noc_pkg::P - 1) ? '0 : win + 1'b1;	// one past the winner
		end
	end

endmodule

/* hw/start_delay_gen.sv */
`timescale 1ns/10ps

module start_delay_gen (
	input  logic                   clk,
	input  logic                   reset,
	input  logic                   start_i,
	output logic [noc_pkg::NC-1:0] start_o
);

	logic started;	// start request seen
	logic shift_en;	// halves the shift rate

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			started <= 1'b0;
			shift_en <= 1'b0;
			start_o <= '0;
		end else begin
			if (start_i) started <= 1'b1;
			if (started) begin
				shift_en <= ~shift_en;
				// node k is released 2*(k+1) cycles after the request
				if (shift_en) start_o <= {start_o[noc_pkg::NC-2:0], 1'b1};
			end
		end
	end

endmodule

/* run.sh */
#!/usr/bin/env bash
# build and run the mesh testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module noc_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "verilator build failed"
	exit 1
fi

sim_out=$(./obj_dir/Vnoc_tb)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
	echo "simulation exited with status $sim_status"
	exit 1
fi

if grep -q "Done: no errors" <<< "$sim_out"; then
	exit 0
fi
exit 1

/* sim/noc_sva.sv */
`timescale 1ns/10ps

module noc_router_sva (
	input logic                      clk,
	input logic                      reset,
	input logic [noc_pkg::XW-1:0]    x_i,
	input logic [noc_pkg::YW-1:0]    y_i,
	input noc_pkg::link_t            out_o [noc_pkg::P],
	input logic [noc_pkg::CRD_W-1:0] crd_cnt [noc_pkg::P],
	input logic [noc_pkg::P-1:0]     gnt [noc_pkg::P]
);

	for (genvar o = 0; o < noc_pkg::P; o++) begin : g_port
		// local output drains into the ejection buffer
		localparam int MAX_CRD = (o == int'(noc_pkg::LOCAL)) ? noc_pkg::EJ_DEPTH
		                                                     : noc_pkg::BUF_DEPTH;

		// counter still holds the slot the valid flit is about to use
		a_valid_credit: assert property (@(posedge clk) disable iff (reset)
			out_o[o].valid |-> crd_cnt[o] != '0)
			else $error("router output %0d valid with no credit", o);

		a_credit_max: assert property (@(posedge clk) disable iff (reset)
			crd_cnt[o] <= noc_pkg::CRD_W'(MAX_CRD))
			else $error("router output %0d credit counter above buffer depth", o);
	end

	for (genvar i = 0; i < noc_pkg::P; i++) begin : g_in
		logic [noc_pkg::P-1:0] gnt_col;	// outputs granting input i

		for (genvar o = 0; o < noc_pkg::P; o++) begin : g_col
			assign gnt_col[o] = gnt[o][i];
		end

		// a second grant would pop the same head twice
		a_gnt_onehot: assert property (@(posedge clk) disable iff (reset) $onehot0(gnt_col))
			else $error("router input %0d granted by more than one output", i);
	end

	a_east_edge: assert property (@(posedge clk) disable iff (reset)
		(x_i == noc_pkg::XW'(noc_pkg::NX - 1)) |-> !out_o[noc_pkg::EAST].valid)
		else $error("flit sent east off the mesh edge");

	a_north_edge: assert property (@(posedge clk) disable iff (reset)
		(y_i == '0) |-> !out_o[noc_pkg::NORTH].valid)
		else $error("flit sent north off the mesh edge");

	a_west_edge: assert property (@(posedge clk) disable iff (reset)
		(x_i == '0) |-> !out_o[noc_pkg::WEST].valid)
		else $error("flit sent west off the mesh edge");

	a_south_edge: assert property (@(posedge clk) disable iff (reset)
		(y_i == noc_pkg::YW'(noc_pkg::NY - 1)) |-> !out_o[noc_pkg::SOUTH].valid)
		else $error("flit sent south off the mesh edge");

endmodule

bind noc_router noc_router_sva i_noc_router_sva (
	.clk     (clk),
	.reset   (reset),
	.x_i     (x_i),
	.y_i     (y_i),
	.out_o   (out_o),
	.crd_cnt (crd_cnt),
	.gnt     (gnt)
);

/* sim/noc_tb.sv */
`timescale 1ns/10ps

module noc_tb;

	localparam int NC = noc_pkg::NC;
	localparam int NX = noc_pkg::NX;
	localparam int PRE_FLITS = 6;	// per core, more than the queue holds
	localparam int N_RAND = 150;
	localparam int N_BP = 160;
	localparam int CENTER = 4;	// hot spot node
	localparam int HOLD_CYC = 40;
	localparam int STALL_CYC = 40;	// quiet cycles that mean injection stalled
	localparam int FLIT_CYC = 20;	// per-flit bound
	localparam int DRAIN_CYC = 2000;
	localparam int TOTAL_FLITS = NC * PRE_FLITS + NC * NC + N_RAND + N_BP;
	localparam int WD_NS = (TOTAL_FLITS * FLIT_CYC + DRAIN_CYC) * 4;

	logic clk;
	logic reset;
	logic start_i;
	noc_pkg::link_t inj_flit [NC];
	logic inj_credit [NC];
	noc_pkg::link_t ej_flit [NC];
	logic ej_credit [NC];

	logic [31:0] lfsr;
	logic [19:0] pend_q [NC][$];	// dst node and data, still at the core
	logic [15:0] exp_q [NC*NC][$];	// src * NC + dst
	int inj_crd [NC];
	int ej_out [NC];	// eject credits granted and not yet used
	logic ej_hold [NC];
	logic inj_gate;
	logic start_pulse;
	int in_flight;
	int rx_count;
	int crd_used;
	int crd_returned;
	int idle_cyc;	// cycles since the last injection credit
	int errors;
	int checks;
	int tests;
	int tests_failed;
	int test_err0;
	string cur_test;

	noc_top i_noc_top (
		.clk          (clk),
		.reset        (reset),
		.start_i      (start_i),
		.inj_flit_i   (inj_flit),
		.inj_credit_o (inj_credit),
		.ej_flit_o    (ej_flit),
		.ej_credit_i  (ej_credit)
	);

	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		#(WD_NS);
		$display("Timeout: traffic did not drain within %0d ns, the network looks stuck", WD_NS);
		$display("Done: errors found");
		$finish;
	end

	// taps 32 22 2 1
	function automatic logic [31:0] lfsr_step(input logic [31:0] s);
		return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
	endfunction

	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		r = '0;
		for (int i = 0; i < n; i++) begin
			lfsr = lfsr_step(lfsr);
			r = {r[30:0], lfsr[0]};
		end
		return r;
	endfunction

	task automatic check(input string what, input logic [31:0] exp, input logic [31:0] act);
		checks++;
		if (exp !== act) begin
			$display("Error: test %s, %s: expected %0h, actual %0h", cur_test, what, exp, act);
			errors++;
		end
	endtask

	task automatic report_failure(input string msg);
		$display("%s (test %s)", msg, cur_test);
		errors++;
	endtask

	task automatic queue_flit(input int src, input int dst, input logic [15:0] data);
		pend_q[src].push_back({4'(dst), data});
	endtask

	function automatic int pend_total();
		int n;
		n = 0;
		for (int c = 0; c < NC; c++) n += pend_q[c].size();
		return n;
	endfunction

	task automatic drive_inputs();
		logic [19:0] req;
		int dst;
		start_i = start_pulse;
		start_pulse = 1'b0;
		for (int c = 0; c < NC; c++) begin
			inj_flit[c] = '0;
			ej_credit[c] = 1'b0;
			if (pend_q[c].size() > 0 && inj_crd[c] > 0 && (!inj_gate || rand_bits(1) == 1)) begin
				req = pend_q[c].pop_front();
				dst = int'(req[19:16]);
				inj_flit[c].valid = 1'b1;
				inj_flit[c].flit.dst_x = noc_pkg::XW'(dst % NX);
				inj_flit[c].flit.dst_y = noc_pkg::YW'(dst / NX);
				inj_flit[c].flit.data = req[15:0];
				exp_q[c * NC + dst].push_back(req[15:0]);	// injection order per pair
				inj_crd[c]--;
				crd_used++;
				in_flight++;
			end
			// core hands out space in its own eject buffer
			if (!ej_hold[c] && ej_out[c] < noc_pkg::EJ_DEPTH && rand_bits(1) == 1) begin
				ej_credit[c] = 1'b1;
				ej_out[c]++;
			end
		end
	endtask

	task automatic receive_flit(input int c, input noc_pkg::flit_t f);
		int idx;
		rx_count++;
		if (ej_out[c] == 0) report_failure($sformatf("core %0d got a flit it had no room for", c));
		else ej_out[c]--;
		check($sformatf("dst_x at core %0d", c), 32'(c % NX), 32'(f.dst_x));
		check($sformatf("dst_y at core %0d", c), 32'(c / NX), 32'(f.dst_y));
		if (int'(f.src) >= NC) begin
			report_failure($sformatf("core %0d got a flit from unknown source %0d", c, f.src));
		end else begin
			idx = int'(f.src) * NC + c;
			if (exp_q[idx].size() == 0) begin
				report_failure($sformatf("core %0d got an unexpected flit from core %0d, data %h",
				                         c, f.src, f.data));
			end else begin
				check($sformatf("data %0d->%0d", f.src, c), 32'(exp_q[idx][0]), 32'(f.data));
				void'(exp_q[idx].pop_front());
				in_flight--;
			end
		end
	endtask

	task automatic sample_outputs();
		logic got;
		got = 1'b0;
		for (int c = 0; c < NC; c++) begin
			if (inj_credit[c]) begin
				got = 1'b1;
				crd_returned++;
				if (inj_crd[c] >= noc_pkg::INJ_DEPTH)
					report_failure($sformatf("core %0d got back a credit it never used", c));
				else
					inj_crd[c]++;
			end
			if (ej_flit[c].valid) receive_flit(c, ej_flit[c].flit);
		end
		idle_cyc = got ? 0 : idle_cyc + 1;
	endtask

	// drive after the rising edge, sample on the falling edge
	task automatic step(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
			drive_inputs();
			@(negedge clk);
			sample_outputs();
		end
	endtask

	task automatic wait_drain();
		while (pend_total() > 0 || in_flight > 0) step(1);
		step(4);
	endtask

	task automatic check_queues_empty();
		for (int i = 0; i < NC * NC; i++)
			check($sformatf("pair %0d->%0d left over", i / NC, i % NC), 0, 32'(exp_q[i].size()));
	endtask

	task automatic begin_test(input string name);
		cur_test = name;
		test_err0 = errors;
	endtask

	task automatic end_test();
		tests++;
		if (errors == test_err0) begin
			$display("test %s ok", cur_test);
		end else begin
			tests_failed++;
			$display("test %s FAILED with %0d errors", cur_test, errors - test_err0);
		end
	endtask

	task automatic hold_before_start();
		int rx0;
		begin_test("hold_before_start");
		rx0 = rx_count;
		for (int c = 0; c < NC; c++)
			for (int k = 0; k < PRE_FLITS; k++)
				queue_flit(c, int'(rand_bits(4)) % NC, 16'(rand_bits(16)));
		step(HOLD_CYC);
		check("flits ejected before start", 0, 32'(rx_count - rx0));
		check("credits returned before start", 0, 32'(crd_returned));
		for (int c = 0; c < NC; c++)
			check($sformatf("core %0d credits left before start", c), 0, 32'(inj_crd[c]));
		start_pulse = 1'b1;
		wait_drain();
		check_queues_empty();
		end_test();
	endtask

	task automatic cover_all_pairs();
		begin_test("all_pairs");
		for (int s = 0; s < NC; s++)
			for (int d = 0; d < NC; d++)
				queue_flit(s, d, 16'(rand_bits(16)));
		wait_drain();
		check_queues_empty();
		end_test();
	endtask

	task automatic random_traffic();
		begin_test("random_traffic");
		inj_gate = 1'b1;	// cores inject on a coin flip
		for (int k = 0; k < N_RAND; k++)
			queue_flit(int'(rand_bits(4)) % NC, int'(rand_bits(4)) % NC, 16'(rand_bits(16)));
		wait_drain();
		inj_gate = 1'b0;
		check_queues_empty();
		end_test();
	endtask

	task automatic back_pressure();
		int rx0;
		int cr0;
		int left;
		begin_test("back_pressure");
		left = 0;
		for (int c = 0; c < NC; c++) begin
			ej_hold[c] = 1'b1;
			left += ej_out[c];	// grants already out may still be used
		end
		rx0 = rx_count;
		cr0 = crd_returned;
		for (int k = 0; k < N_BP; k++)
			queue_flit(int'(rand_bits(4)) % NC, CENTER, 16'(rand_bits(16)));
		while (crd_returned == cr0) step(1);
		while (idle_cyc < STALL_CYC) step(1);
		if (rx_count - rx0 > left)
			report_failure("flits were delivered beyond the eject credits granted");
		if (pend_total() == 0)
			report_failure("injection never stalled while eject credits were withheld");
		for (int c = 0; c < NC; c++) ej_hold[c] = 1'b0;
		wait_drain();
		check_queues_empty();
		end_test();
	endtask

	task automatic credit_accounting();
		begin_test("credit_accounting");
		for (int c = 0; c < NC; c++)
			check($sformatf("core %0d injection credits", c), noc_pkg::INJ_DEPTH, 32'(inj_crd[c]));
		check("credits returned vs used", 32'(crd_used), 32'(crd_returned));
		end_test();
	endtask

	initial begin
		reset = 1'b1;
		start_i = 1'b0;
		start_pulse = 1'b0;
		inj_gate = 1'b0;
		lfsr = 32'h3563d766;
		in_flight = 0;
		rx_count = 0;
		crd_used = 0;
		crd_returned = 0;
		idle_cyc = 0;
		errors = 0;
		checks = 0;
		tests = 0;
		tests_failed = 0;
		cur_test = "reset";
		for (int c = 0; c < NC; c++) begin
			inj_flit[c] = '0;
			ej_credit[c] = 1'b0;
			inj_crd[c] = noc_pkg::INJ_DEPTH;
			ej_out[c] = 0;
			ej_hold[c] = 1'b0;
		end
		repeat (10) @(posedge clk);
		#1;
		reset = 1'b0;
		step(2);
		hold_before_start();
		cover_all_pairs();
		random_traffic();
		back_pressure();
		credit_accounting();
		$display("%0d tests, %0d failed, %0d checks, %0d errors", tests, tests_failed, checks, errors);
		if (errors == 0)
			$display("Done: no errors");
		else
			$display("Done: errors found");
		$finish;
	end

endmodule
